// File: build.f
source/rv_pkg.sv
source/fetch_stage.sv
source/controller.sv
source/extend.sv
source/regfile.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/hazard_unit.sv
source/rv_core.sv
test/tb_rv_core.sv

// File: source/controller.sv
// ####################
// Main decoder and ALU decoder
// ####################
`default_nettype none

module controller (
    input  wire logic [6:0]   i_op,
    input  wire logic [2:0]   i_funct3,
    input  wire logic         i_funct7b5,
    output rv_pkg::ctrl_t     o_ctrl,
    output rv_pkg::imm_src_e  o_immsrc
);

    // ALU class: 00 add, 01 sub, 10 from funct3
    logic [1:0]      l_aluop;
    rv_pkg::ctrl_t   l_ctrl;
    rv_pkg::alu_op_e l_aluctrl;

    // Main decoder, unknown opcodes stay all zero
    always_comb begin
        l_ctrl   = '0;
        o_immsrc = rv_pkg::IMM_I;
        l_aluop  = 2'b00;
        case (i_op)
            rv_pkg::OP_R: begin
                l_ctrl.regwrite = 1'b1;
                l_aluop         = 2'b10;
            end
            rv_pkg::OP_I: begin
                l_ctrl.regwrite = 1'b1;
                l_ctrl.alusrc   = 1'b1;
                l_aluop         = 2'b10;
            end
            rv_pkg::OP_LW: begin
                l_ctrl.regwrite  = 1'b1;
                l_ctrl.resultsrc = rv_pkg::RES_LOAD;
                l_ctrl.memread   = 1'b1;
                l_ctrl.alusrc    = 1'b1;
            end
            rv_pkg::OP_SW: begin
                l_ctrl.memwrite = 1'b1;
                l_ctrl.alusrc   = 1'b1;
                o_immsrc        = rv_pkg::IMM_S;
            end
            rv_pkg::OP_BEQ: begin
                l_ctrl.branch = 1'b1;
                o_immsrc      = rv_pkg::IMM_B;
                l_aluop       = 2'b01;
            end
            rv_pkg::OP_JAL: begin
                l_ctrl.regwrite  = 1'b1;
                l_ctrl.resultsrc = rv_pkg::RES_PC4;
                l_ctrl.jump      = 1'b1;
                o_immsrc         = rv_pkg::IMM_J;
            end
            default: begin
            end
        endcase
    end

    // ALU decoder, funct7 bit 5 only splits add and sub on R-type
    always_comb begin
        case (l_aluop)
            2'b00: l_aluctrl = rv_pkg::ALU_ADD;
            2'b01: l_aluctrl = rv_pkg::ALU_SUB;
            default: begin
                case (i_funct3)
                    3'b000: begin
                        if ((i_op == rv_pkg::OP_R) && i_funct7b5) begin
                            l_aluctrl = rv_pkg::ALU_SUB;
                        end else begin
                            l_aluctrl = rv_pkg::ALU_ADD;
                        end
                    end
                    3'b010:  l_aluctrl = rv_pkg::ALU_SLT;
                    3'b110:  l_aluctrl = rv_pkg::ALU_OR;
                    3'b111:  l_aluctrl = rv_pkg::ALU_AND;
                    default: l_aluctrl = rv_pkg::ALU_ADD;
                endcase
            end
        endcase
    end

    always_comb begin
        o_ctrl         = l_ctrl;
        o_ctrl.aluctrl = l_aluctrl;
    end

endmodule

`default_nettype wire

// File: source/decode_stage.sv
// ####################
// Decode stage
// Field extraction, controller, register file, extender
// ID/EX register with stall and flush
// ####################
`default_nettype none

module decode_stage #(
    parameter int PC_WIDTH = 10
) (
    input  wire logic                i_clk,
    input  wire logic                i_rst_n,
    input  wire logic                i_stall,
    input  wire logic                i_flush_e,
    input  wire rv_pkg::word_t       i_instr_d,
    input  wire logic [PC_WIDTH-1:0] i_pc_d,
    input  wire logic [PC_WIDTH-1:0] i_pc4_d,
    input  wire rv_pkg::reg_wr_t     i_wr,
    output rv_pkg::id_ex_t           o_id_ex,
    output rv_pkg::reg_addr_t        o_rs1_addr_d,
    output rv_pkg::reg_addr_t        o_rs2_addr_d
);

    rv_pkg::reg_addr_t l_rd;
    rv_pkg::ctrl_t     l_ctrl;
    rv_pkg::imm_src_e  l_immsrc;
    rv_pkg::word_t     l_rs1_data;
    rv_pkg::word_t     l_rs2_data;
    rv_pkg::word_t     l_immext;
    rv_pkg::id_ex_t    l_next;

    // Register fields, rs addresses also go to load-use detection
    assign o_rs1_addr_d = i_instr_d[19:15];
    assign o_rs2_addr_d = i_instr_d[24:20];
    assign l_rd         = i_instr_d[11:7];

    controller u_controller (
        .i_op       (i_instr_d[6:0]),
        .i_funct3   (i_instr_d[14:12]),
        .i_funct7b5 (i_instr_d[30]),
        .o_ctrl     (l_ctrl),
        .o_immsrc   (l_immsrc)
    );

    regfile u_regfile (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wr       (i_wr),
        .i_rs1_addr (o_rs1_addr_d),
        .i_rs2_addr (o_rs2_addr_d),
        .o_rs1_data (l_rs1_data),
        .o_rs2_data (l_rs2_data)
    );

    extend u_extend (
        .i_instr  (i_instr_d[31:7]),
        .i_immsrc (l_immsrc),
        .o_immext (l_immext)
    );

    // Next ID/EX contents
    always_comb begin
        l_next.ctrl          = l_ctrl;
        // Writes to x0 are dropped here, never reach writeback
        l_next.ctrl.regwrite = l_ctrl.regwrite & (l_rd != '0);
        l_next.rs1_data      = l_rs1_data;
        l_next.rs2_data      = l_rs2_data;
        l_next.imm           = l_immext;
        l_next.rs1           = o_rs1_addr_d;
        l_next.rs2           = o_rs2_addr_d;
        l_next.rd            = l_rd;
        l_next.pc            = rv_pkg::word_t'(i_pc_d);
        l_next.pc4           = rv_pkg::word_t'(i_pc4_d);
    end

    // Memory stall holds execute, so it beats flush
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_id_ex <= '0;
        end else if (!i_stall) begin
            if (i_flush_e) begin
                o_id_ex <= '0;
            end else begin
                o_id_ex <= l_next;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/execute_stage.sv
// ####################
// Execute stage
// Forward muxes, ALU, branch decision, target adder, EX/MEM
// ####################
`default_nettype none

module execute_stage #(
    parameter int PC_WIDTH = 10
) (
    input  wire logic              i_clk,
    input  wire logic              i_rst_n,
    input  wire logic              i_stall,
    input  wire rv_pkg::id_ex_t    i_id_ex,
    input  wire logic [1:0]        i_fwd_a,
    input  wire logic [1:0]        i_fwd_b,
    input  wire rv_pkg::word_t     i_fwd_mem,
    input  wire rv_pkg::word_t     i_fwd_wb,
    output rv_pkg::ex_mem_t        o_ex_mem,
    output logic                   o_pcsrc,
    output logic [PC_WIDTH-1:0]    o_target
);

    rv_pkg::word_t l_op_a;
    rv_pkg::word_t l_op_b;
    rv_pkg::word_t l_hold_a;
    rv_pkg::word_t l_hold_b;
    logic          l_hold_vld;
    rv_pkg::word_t l_alu_b;
    rv_pkg::word_t l_alu;
    logic          l_lt;
    logic          l_zero;

    function automatic rv_pkg::word_t fwd_mux(input logic [1:0] sel,
                                              input rv_pkg::word_t reg_val,
                                              input rv_pkg::word_t mem_val,
                                              input rv_pkg::word_t wb_val);
        case (sel)
            rv_pkg::FWD_MEM: return mem_val;
            rv_pkg::FWD_WB:  return wb_val;
            default:         return reg_val;
        endcase
    endfunction

    // Writeback drains during a memory wait
    // Operands captured on the first stalled cycle are reused until release
    always_comb begin
        if (l_hold_vld) begin
            l_op_a = l_hold_a;
            l_op_b = l_hold_b;
        end else begin
            l_op_a = fwd_mux(i_fwd_a, i_id_ex.rs1_data, i_fwd_mem, i_fwd_wb);
            l_op_b = fwd_mux(i_fwd_b, i_id_ex.rs2_data, i_fwd_mem, i_fwd_wb);
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            l_hold_vld <= 1'b0;
        end else begin
            l_hold_vld <= i_stall;
        end
    end

    always_ff @(posedge i_clk) begin
        l_hold_a <= l_op_a;
        l_hold_b <= l_op_b;
    end

    // ALU
    assign l_alu_b = i_id_ex.ctrl.alusrc ? i_id_ex.imm : l_op_b;
    assign l_lt    = $signed(l_op_a) < $signed(l_alu_b);

    always_comb begin
        case (i_id_ex.ctrl.aluctrl)
            rv_pkg::ALU_SUB: l_alu = l_op_a - l_alu_b;
            rv_pkg::ALU_AND: l_alu = l_op_a & l_alu_b;
            rv_pkg::ALU_OR:  l_alu = l_op_a | l_alu_b;
            rv_pkg::ALU_SLT: l_alu = {{(rv_pkg::XLEN-1){1'b0}}, l_lt};
            default:         l_alu = l_op_a + l_alu_b;
        endcase
    end

    // Taken beq or any jal redirects fetch
    assign l_zero   = (l_alu == '0);
    assign o_pcsrc  = (i_id_ex.ctrl.branch & l_zero) | i_id_ex.ctrl.jump;
    assign o_target = i_id_ex.pc[PC_WIDTH-1:0] + i_id_ex.imm[PC_WIDTH-1:0];

    // EX/MEM register, holds while memory waits
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ex_mem <= '0;
        end else if (!i_stall) begin
            o_ex_mem.ctrl       <= i_id_ex.ctrl;
            o_ex_mem.alu_result <= l_alu;
            o_ex_mem.store_data <= l_op_b;
            o_ex_mem.rd         <= i_id_ex.rd;
            o_ex_mem.pc4        <= i_id_ex.pc4;
        end
    end

endmodule

`default_nettype wire

// File: source/extend.sv
// ####################
// Immediate extender, I S B J forms
// ####################
`default_nettype none

module extend (
    input  wire logic [31:7]        i_instr,
    input  wire rv_pkg::imm_src_e   i_immsrc,
    output rv_pkg::word_t           o_immext
);

    // Sign bit is always instruction bit 31
    always_comb begin
        case (i_immsrc)
            rv_pkg::IMM_S: o_immext = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            rv_pkg::IMM_B: o_immext = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25],
                                       i_instr[11:8], 1'b0};
            rv_pkg::IMM_J: o_immext = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20],
                                       i_instr[30:21], 1'b0};
            default:       o_immext = {{20{i_instr[31]}}, i_instr[31:20]};
        endcase
    end

endmodule

`default_nettype wire

// File: source/fetch_stage.sv
// ####################
// Fetch stage
// Program counter with stall and redirect, IF/ID register
// ####################
`default_nettype none

module fetch_stage #(
    parameter int PC_WIDTH = 10
) (
    input  wire logic                i_clk,
    input  wire logic                i_rst_n,
    input  wire logic                i_stall,
    input  wire logic                i_flush,
    input  wire logic                i_pcsrc,
    input  wire logic [PC_WIDTH-1:0] i_target,
    input  wire rv_pkg::word_t       i_instr,
    output logic [PC_WIDTH-1:0]      o_pc,
    output rv_pkg::word_t            o_instr_d,
    output logic [PC_WIDTH-1:0]      o_pc_d,
    output logic [PC_WIDTH-1:0]      o_pc4_d
);

    localparam logic [PC_WIDTH-1:0] PC_STEP = PC_WIDTH'(4);

    logic [PC_WIDTH-1:0] l_pc4;

    assign l_pc4 = o_pc + PC_STEP;

    // Taken redirect beats a stall
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pc <= '0;
        end else if (i_pcsrc) begin
            o_pc <= i_target;
        end else if (!i_stall) begin
            o_pc <= l_pc4;
        end
    end

    // IF/ID register, flush inserts a nop
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_instr_d <= rv_pkg::NOP_INSTR;
            o_pc_d    <= '0;
            o_pc4_d   <= '0;
        end else if (i_flush) begin
            o_instr_d <= rv_pkg::NOP_INSTR;
        end else if (!i_stall) begin
            o_instr_d <= i_instr;
            o_pc_d    <= o_pc;
            o_pc4_d   <= l_pc4;
        end
    end

endmodule

`default_nettype wire

// File: source/hazard_unit.sv
// ####################
// Hazard unit
// Forward selects, load-use and memory stalls, flushes
// ####################
`default_nettype none

module hazard_unit (
    input  wire rv_pkg::reg_addr_t i_rs1_d,
    input  wire rv_pkg::reg_addr_t i_rs2_d,
    input  wire rv_pkg::reg_addr_t i_rs1_e,
    input  wire rv_pkg::reg_addr_t i_rs2_e,
    input  wire rv_pkg::reg_addr_t i_rd_e,
    input  wire logic              i_memread_e,
    input  wire rv_pkg::reg_addr_t i_rd_m,
    input  wire logic              i_regwrite_m,
    input  wire logic              i_wait_m,
    input  wire rv_pkg::reg_wr_t   i_wr_w,
    input  wire logic              i_pcsrc_e,
    output logic [1:0]             o_fwd_a,
    output logic [1:0]             o_fwd_b,
    output logic                   o_stall_fd,
    output logic                   o_stall_all,
    output logic                   o_flush_d,
    output logic                   o_flush_e
);

    logic l_lwstall;

    // Memory beats writeback, x0 never forwards
    function automatic logic [1:0] fwd_sel(input rv_pkg::reg_addr_t rs);
        if (i_regwrite_m && (i_rd_m != '0) && (i_rd_m == rs)) begin
            return rv_pkg::FWD_MEM;
        end else if (i_wr_w.we && (i_wr_w.rd != '0) && (i_wr_w.rd == rs)) begin
            return rv_pkg::FWD_WB;
        end
        return rv_pkg::FWD_REG;
    endfunction

    always_comb begin
        o_fwd_a = fwd_sel(i_rs1_e);
        o_fwd_b = fwd_sel(i_rs2_e);
    end

    // Load in execute feeding the instruction in decode
    assign l_lwstall = i_memread_e & (i_rd_e != '0) &
                       ((i_rd_e == i_rs1_d) | (i_rd_e == i_rs2_d));

    assign o_stall_fd  = l_lwstall | i_wait_m;
    assign o_stall_all = i_wait_m;
    assign o_flush_d   = i_pcsrc_e;
    assign o_flush_e   = i_pcsrc_e | l_lwstall;

endmodule

`default_nettype wire

// File: source/memory_stage.sv
// ####################
// Memory stage
// Wishbone classic master, wait request, MEM/WB register
// ####################
`default_nettype none

module memory_stage (
    input  wire logic             i_clk,
    input  wire logic             i_rst_n,
    input  wire rv_pkg::ex_mem_t  i_ex_mem,
    output rv_pkg::wb_m2s_t       o_wb,
    input  wire rv_pkg::wb_s2m_t  i_wb,
    output logic                  o_wait,
    output rv_pkg::word_t         o_fwd_data,
    output rv_pkg::reg_wr_t       o_mem_wr
);

    logic          l_access;
    rv_pkg::word_t l_result;

    assign l_access = i_ex_mem.ctrl.memread | i_ex_mem.ctrl.memwrite;

    // Request straight from EX/MEM, held there until ack
    always_comb begin
        o_wb.cyc = l_access;
        o_wb.stb = l_access;
        o_wb.we  = i_ex_mem.ctrl.memwrite;
        o_wb.adr = i_ex_mem.alu_result;
        o_wb.dat = i_ex_mem.store_data;
        // Word accesses only
        o_wb.sel = 4'hF;
    end

    assign o_wait = l_access & ~i_wb.ack;

    // Loads never forward from here, load-use stall covers them
    assign o_fwd_data = (i_ex_mem.ctrl.resultsrc == rv_pkg::RES_PC4) ?
                        i_ex_mem.pc4 : i_ex_mem.alu_result;

    // Writeback select
    always_comb begin
        case (i_ex_mem.ctrl.resultsrc)
            rv_pkg::RES_LOAD: l_result = i_wb.dat;
            rv_pkg::RES_PC4:  l_result = i_ex_mem.pc4;
            default:          l_result = i_ex_mem.alu_result;
        endcase
    end

    // MEM/WB register, bubble on every waiting cycle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mem_wr <= '0;
        end else if (o_wait) begin
            o_mem_wr <= '0;
        end else begin
            o_mem_wr.we   <= i_ex_mem.ctrl.regwrite;
            o_mem_wr.rd   <= i_ex_mem.rd;
            o_mem_wr.data <= l_result;
        end
    end

endmodule

`default_nettype wire

// File: source/regfile.sv
// ####################
// Register file, x0 fixed at zero
// Write-through reads
// ####################
`default_nettype none

module regfile (
    input  wire logic              i_clk,
    input  wire logic              i_rst_n,
    input  wire rv_pkg::reg_wr_t   i_wr,
    input  wire rv_pkg::reg_addr_t i_rs1_addr,
    input  wire rv_pkg::reg_addr_t i_rs2_addr,
    output rv_pkg::word_t          o_rs1_data,
    output rv_pkg::word_t          o_rs2_data
);

    rv_pkg::word_t l_regs [32];
    logic          l_wen;

    // Entry 0 is never written
    assign l_wen = i_wr.we & (i_wr.rd != '0);

    // Bypass a same-cycle write so decode sees the new value
    function automatic rv_pkg::word_t read_port(input rv_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (l_wen && (addr == i_wr.rd)) begin
            return i_wr.data;
        end
        return l_regs[addr];
    endfunction

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 32; i++) begin
                l_regs[i] <= '0;
            end
        end else if (l_wen) begin
            l_regs[i_wr.rd] <= i_wr.data;
        end
    end

    always_comb begin
        o_rs1_data = read_port(i_rs1_addr);
        o_rs2_data = read_port(i_rs2_addr);
    end

endmodule

`default_nettype wire

// File: source/rv_core.sv
// ####################
// Five-stage RV32I subset core
// Stage chain and hazard unit
// ####################
`default_nettype none

module rv_core #(
    parameter int PC_WIDTH = 10
) (
    input  wire logic             i_clk,
    input  wire logic             i_rst_n,
    output logic [PC_WIDTH-1:0]   o_imem_addr,
    input  wire rv_pkg::word_t    i_imem_data,
    output rv_pkg::wb_m2s_t       o_wb,
    input  wire rv_pkg::wb_s2m_t  i_wb,
    output rv_pkg::reg_wr_t       o_reg_wr
);

    // IF/ID
    rv_pkg::word_t       l_instr_d;
    logic [PC_WIDTH-1:0] l_pc_d;
    logic [PC_WIDTH-1:0] l_pc4_d;
    // Decode and execute
    rv_pkg::id_ex_t      l_id_ex;
    rv_pkg::reg_addr_t   l_rs1_d;
    rv_pkg::reg_addr_t   l_rs2_d;
    rv_pkg::ex_mem_t     l_ex_mem;
    logic                l_pcsrc;
    logic [PC_WIDTH-1:0] l_target;
    // Memory
    logic                l_wait;
    rv_pkg::word_t       l_fwd_mem;
    // Hazard controls
    logic [1:0]          l_fwd_a;
    logic [1:0]          l_fwd_b;
    logic                l_stall_fd;
    logic                l_stall_all;
    logic                l_flush_d;
    logic                l_flush_e;

    fetch_stage #(
        .PC_WIDTH (PC_WIDTH)
    ) u_fetch (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_stall   (l_stall_fd),
        .i_flush   (l_flush_d),
        .i_pcsrc   (l_pcsrc),
        .i_target  (l_target),
        .i_instr   (i_imem_data),
        .o_pc      (o_imem_addr),
        .o_instr_d (l_instr_d),
        .o_pc_d    (l_pc_d),
        .o_pc4_d   (l_pc4_d)
    );

    // Writeback bus feeds the register file and the trace port
    decode_stage #(
        .PC_WIDTH (PC_WIDTH)
    ) u_decode (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_stall      (l_stall_all),
        .i_flush_e    (l_flush_e),
        .i_instr_d    (l_instr_d),
        .i_pc_d       (l_pc_d),
        .i_pc4_d      (l_pc4_d),
        .i_wr         (o_reg_wr),
        .o_id_ex      (l_id_ex),
        .o_rs1_addr_d (l_rs1_d),
        .o_rs2_addr_d (l_rs2_d)
    );

    execute_stage #(
        .PC_WIDTH (PC_WIDTH)
    ) u_execute (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_stall   (l_stall_all),
        .i_id_ex   (l_id_ex),
        .i_fwd_a   (l_fwd_a),
        .i_fwd_b   (l_fwd_b),
        .i_fwd_mem (l_fwd_mem),
        .i_fwd_wb  (o_reg_wr.data),
        .o_ex_mem  (l_ex_mem),
        .o_pcsrc   (l_pcsrc),
        .o_target  (l_target)
    );

    memory_stage u_memory (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_ex_mem   (l_ex_mem),
        .o_wb       (o_wb),
        .i_wb       (i_wb),
        .o_wait     (l_wait),
        .o_fwd_data (l_fwd_mem),
        .o_mem_wr   (o_reg_wr)
    );

    hazard_unit u_hazard (
        .i_rs1_d      (l_rs1_d),
        .i_rs2_d      (l_rs2_d),
        .i_rs1_e      (l_id_ex.rs1),
        .i_rs2_e      (l_id_ex.rs2),
        .i_rd_e       (l_id_ex.rd),
        .i_memread_e  (l_id_ex.ctrl.memread),
        .i_rd_m       (l_ex_mem.rd),
        .i_regwrite_m (l_ex_mem.ctrl.regwrite),
        .i_wait_m     (l_wait),
        .i_wr_w       (o_reg_wr),
        .i_pcsrc_e    (l_pcsrc),
        .o_fwd_a      (l_fwd_a),
        .o_fwd_b      (l_fwd_b),
        .o_stall_fd   (l_stall_fd),
        .o_stall_all  (l_stall_all),
        .o_flush_d    (l_flush_d),
        .o_flush_e    (l_flush_e)
    );

endmodule

`default_nettype wire

// File: source/rv_pkg.sv
// ####################
// Shared RV32I subset definitions
// Widths, opcodes, ALU, immediate and writeback codes
// Control, stage and Wishbone bus structs
// ####################
`default_nettype none

package rv_pkg;

    // ISA widths
    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // Major opcodes of the supported subset
    localparam logic [6:0] OP_R   = 7'b0110011;
    localparam logic [6:0] OP_I   = 7'b0010011;
    localparam logic [6:0] OP_LW  = 7'b0000011;
    localparam logic [6:0] OP_SW  = 7'b0100011;
    localparam logic [6:0] OP_BEQ = 7'b1100011;
    localparam logic [6:0] OP_JAL = 7'b1101111;

    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

    // Forward selects into execute
    localparam logic [1:0] FWD_REG = 2'b00;
    localparam logic [1:0] FWD_WB  = 2'b01;
    localparam logic [1:0] FWD_MEM = 2'b10;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_SLT = 3'b101
    } alu_op_e;

    typedef enum logic [1:0] {
        IMM_I = 2'b00,
        IMM_S = 2'b01,
        IMM_B = 2'b10,
        IMM_J = 2'b11
    } imm_src_e;

    typedef enum logic [1:0] {
        RES_ALU  = 2'b00,
        RES_LOAD = 2'b01,
        RES_PC4  = 2'b10
    } res_src_e;

    // Control bundle, all zero is a bubble
    typedef struct packed {
        logic     regwrite;
        res_src_e resultsrc;
        logic     memwrite;
        logic     memread;
        logic     jump;
        logic     branch;
        alu_op_e  aluctrl;
        logic     alusrc;
    } ctrl_t;

    // Register file write, also the trace bus
    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } reg_wr_t;

    // PC fields are zero-extended byte addresses
    typedef struct packed {
        ctrl_t     ctrl;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     pc;
        word_t     pc4;
    } id_ex_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t rd;
        word_t     pc4;
    } ex_mem_t;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        word_t      adr;
        word_t      dat;
        logic [3:0] sel;
    } wb_m2s_t;

    // Wishbone classic, slave to master
    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_s2m_t;

endpackage

`default_nettype wire

// File: test/program_input.hex
// One hex entry per line, up to 64 bits, sections placed by @ addresses
// @00 program, @40 data words, @60 counts, @70 writes {we,rd,data}, @a0 stores {adr,dat}
@00
00500093 // addi x1, x0, 5
ffd00113 // addi x2, x0, -3
002081b3 // add  x3, x1, x2
40208233 // sub  x4, x1, x2
002272b3 // and  x5, x4, x2
0032e333 // or   x6, x5, x3
001123b3 // slt  x7, x2, x1
0020a433 // slt  x8, x1, x2
00708013 // addi x0, x1, 7
007004b3 // add  x9, x0, x7
02000513 // addi x10, x0, 32
00652023 // sw   x6, 0(x10)
00452583 // lw   x11, 4(x10)
00158633 // add  x12, x11, x1
00052683 // lw   x13, 0(x10)
00d52423 // sw   x13, 8(x10)
00938663 // beq  x7, x9, +12 taken
06300713 // addi x14, x0, 99 skipped
00152023 // sw   x1, 0(x10) skipped
00838463 // beq  x7, x8, +8 not taken
02100793 // addi x15, x0, 33
00c0086f // jal  x16, +12
00152223 // sw   x1, 4(x10) skipped
00100893 // addi x17, x0, 1 skipped
40f80933 // sub  x18, x16, x15
00c52983 // lw   x19, 12(x10)
0129ea33 // or   x20, x19, x18
01452823 // sw   x20, 16(x10)
0000006f // jal  x0, 0
00000013 // nop
00000013 // nop
@40
3c00ff00
00000011
00000022
00000033
00000044
00000055
00000066
00000077
deadbeef
12345678
000000aa
0f0f0000
000000cc
000000dd
000000ee
000000ff
@60
00000012 // register writes
00000003 // stores
@70
2100000005
22fffffffd
2300000002
2400000008
2500000008
260000000a
2700000001
2800000000
2900000001
2a00000020
2b12345678
2c1234567d
2d0000000a
2f00000021
3000000058
3200000037
330f0f0000
340f0f0037
@a0
000000200000000a
000000280000000a
000000300f0f0037

// File: test/tb_rv_core.sv
// ####################
// Testbench for the RV32I subset core
// Clock, reset, fetch responder, Wishbone slave
// Writeback trace and store checks
// ####################
`default_nettype none

module tb_rv_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PC_WIDTH      = 10;
    localparam int PROG_WORDS    = 1 << (PC_WIDTH - 2);
    localparam int DMEM_WORDS    = 64;
    // Hex image layout, in 64-bit entries
    localparam int IMG_PROG      = 'h00;
    localparam int IMG_DATA      = 'h40;
    localparam int IMG_COUNT     = 'h60;
    localparam int IMG_REG       = 'h70;
    localparam int IMG_STORE     = 'ha0;
    localparam int DATA_INIT     = 16;
    localparam int MAX_REG       = 48;
    localparam int MAX_STORE     = 16;
    localparam int EVENT_TIMEOUT = 60;
    localparam int IDLE_CYCLES   = 40;

    logic                clk = 1'b0;
    logic                rst_n = 1'b0;
    logic [PC_WIDTH-1:0] imem_addr;
    rv_pkg::word_t       imem_data;
    rv_pkg::wb_m2s_t     wb_req;
    rv_pkg::wb_s2m_t     wb_rsp = '0;
    rv_pkg::reg_wr_t     reg_wr;

    logic [63:0]         image [0:255];
    rv_pkg::word_t       prog [0:PROG_WORDS-1];
    rv_pkg::word_t       dmem [0:DMEM_WORDS-1];
    rv_pkg::reg_wr_t     exp_reg [0:MAX_REG-1];
    rv_pkg::wb_m2s_t     exp_store [0:MAX_STORE-1];
    int                  n_reg;
    int                  n_store;
    int                  store_count = 0;
    integer              seed;

    // Slave state, only touched by the slave process
    logic                busy = 1'b0;
    int                  wait_left;
    rv_pkg::wb_m2s_t     held_req;

    rv_core #(
        .PC_WIDTH (PC_WIDTH)
    ) UUT (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .o_imem_addr (imem_addr),
        .i_imem_data (imem_data),
        .o_wb        (wb_req),
        .i_wb        (wb_rsp),
        .o_reg_wr    (reg_wr)
    );

    always #2 clk = ~clk;

    // Instruction port answers in the same cycle
    assign imem_data = prog[imem_addr[PC_WIDTH-1:2]];

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_reg_wr(input rv_pkg::reg_wr_t actual,
                                input rv_pkg::reg_wr_t expected, input int index);
        string msg;
        if (actual !== expected) begin
            msg = $sformatf("mismatch at %0d ns: o_reg_wr #%0d", $time, index);
            msg = {msg, $sformatf(" got we=%0b rd=x%0d data=%h,",
                                  actual.we, actual.rd, actual.data)};
            msg = {msg, $sformatf(" expected we=%0b rd=x%0d data=%h",
                                  expected.we, expected.rd, expected.data)};
            abort_run(msg);
        end
    endtask

    task automatic check_store(input rv_pkg::wb_m2s_t actual,
                               input rv_pkg::wb_m2s_t expected, input int index);
        string msg;
        if (actual !== expected) begin
            msg = $sformatf("mismatch at %0d ns: o_wb store #%0d", $time, index);
            msg = {msg, $sformatf(" got adr=%h dat=%h sel=%h we=%0b,",
                                  actual.adr, actual.dat, actual.sel, actual.we)};
            msg = {msg, $sformatf(" expected adr=%h dat=%h sel=%h we=%0b",
                                  expected.adr, expected.dat, expected.sel, expected.we)};
            abort_run(msg);
        end
    endtask

    // Program, data and expected traces from one hex image
    task automatic load_image();
        $readmemh("test/program_input.hex", image);
        for (int i = 0; i < IMG_DATA - IMG_PROG; i++) begin
            prog[i] = image[IMG_PROG + i][31:0];
        end
        // Word pattern built from the byte address
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = 32'hd0d0_0000 | (i << 2);
        end
        for (int i = 0; i < DATA_INIT; i++) begin
            dmem[i] = image[IMG_DATA + i][31:0];
        end
        n_reg   = image[IMG_COUNT][31:0];
        n_store = image[IMG_COUNT + 1][31:0];
        if ((n_reg < 1) || (n_reg > MAX_REG) || (n_store < 1) || (n_store > MAX_STORE)) begin
            abort_run("hex image holds no valid event counts");
        end
        for (int i = 0; i < n_reg; i++) begin
            exp_reg[i] = image[IMG_REG + i][37:0];
        end
        for (int i = 0; i < n_store; i++) begin
            exp_store[i].cyc = 1'b1;
            exp_store[i].stb = 1'b1;
            exp_store[i].we  = 1'b1;
            exp_store[i].adr = image[IMG_STORE + i][63:32];
            exp_store[i].dat = image[IMG_STORE + i][31:0];
            exp_store[i].sel = 4'hF;
        end
    endtask

    // Ack one access, writes are checked against the store list
    task automatic serve_access();
        int word;
        if ((wb_req.adr >= 4 * DMEM_WORDS) || (wb_req.adr[1:0] != 2'b00) ||
            (wb_req.sel != 4'hF)) begin
            abort_run($sformatf("Wishbone access with bad address %h or sel %h",
                                wb_req.adr, wb_req.sel));
        end
        word = wb_req.adr[31:2];
        wb_rsp.ack <= 1'b1;
        if (wb_req.we) begin
            if (store_count >= n_store) begin
                abort_run($sformatf("unexpected Wishbone write to %h", wb_req.adr));
            end
            check_store(wb_req, exp_store[store_count], store_count);
            dmem[word] = wb_req.dat;
            store_count++;
        end else begin
            wb_rsp.dat <= dmem[word];
        end
    endtask

    // Wishbone classic slave with 0 to 3 extra wait cycles
    always @(posedge clk) begin
        if (!rst_n) begin
            wb_rsp <= '0;
            busy = 1'b0;
        end else if (wb_rsp.ack) begin
            // Ack lasts one cycle, stb on the next edge is a new access
            wb_rsp.ack <= 1'b0;
            busy = 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (!busy) begin
                busy      = 1'b1;
                held_req  = wb_req;
                wait_left = $random(seed) & 3;
            end else if (wb_req !== held_req) begin
                abort_run("Wishbone request changed while waiting for ack");
            end
            if (wait_left == 0) begin
                serve_access();
            end else begin
                wait_left--;
            end
        end
    end

    // Next write on the trace bus, sampled mid-cycle
    task automatic wait_reg_write(input int index);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (reg_wr.we !== 1'b1) begin
            if (cycles >= EVENT_TIMEOUT) begin
                abort_run($sformatf("timeout: register write #%0d to x%0d never arrived",
                                    index, exp_reg[index].rd));
            end
            cycles++;
            @(negedge clk);
        end
        check_reg_wr(reg_wr, exp_reg[index], index);
    endtask

    task automatic wait_stores_done();
        int cycles;
        cycles = 0;
        while (store_count < n_store) begin
            if (cycles >= EVENT_TIMEOUT) begin
                abort_run($sformatf("timeout: store #%0d never reached the Wishbone bus",
                                    store_count));
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    // Core spins on its final jal, nothing may write now
    task automatic check_idle();
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            if (reg_wr.we !== 1'b0) begin
                abort_run($sformatf("extra register write to x%0d after the program end",
                                    reg_wr.rd));
            end
        end
    endtask

    initial begin
        seed = 32'h698a_b404;
        load_image();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < n_reg; i++) begin
            wait_reg_write(i);
        end
        wait_stores_done();
        check_idle();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire
